//--- hw/lpif_pkg.sv
// Lane and word geometry, packed field offsets, vector types and auto-sync states
package lpif_pkg;

  //////////////////////////////////////////////////////////////////////
  // Lane geometry
  //////////////////////////////////////////////////////////////////////

  // Four PHY lanes per link
  localparam int LANE_COUNT     = 4;
  localparam int LANE_WIDTH     = 80;
  // Strobe on bit 0 and marker on bit 79
  localparam int LANE_DATA_BITS = LANE_WIDTH - 2;
  localparam int PAYLOAD_BITS   = LANE_COUNT * LANE_DATA_BITS;
  localparam int WORD_WIDTH     = 281;
  // Word bits that land on the top lane
  localparam int LAST_LANE_BITS = WORD_WIDTH - (LANE_COUNT - 1) * LANE_DATA_BITS;
  localparam int MARKER_WIDTH   = 2;
  localparam int DELAY_WIDTH    = 16;

  // User field widths
  localparam int STATE_WIDTH    = 4;
  localparam int PROTID_WIDTH   = 2;
  localparam int DATA_WIDTH     = 256;
  localparam int CRC_WIDTH      = 16;

  //////////////////////////////////////////////////////////////////////
  // Packed word layout, LSB first
  //////////////////////////////////////////////////////////////////////

  localparam int VALID_BIT      = 0;
  localparam int CRC_VALID_BIT  = 1;
  localparam int CRC_LSB        = 2;
  localparam int DVALID_BIT     = CRC_LSB + CRC_WIDTH;
  localparam int DATA_LSB       = DVALID_BIT + 1;
  localparam int PROTID_LSB     = DATA_LSB + DATA_WIDTH;
  // State sits on top, ends at bit 280
  localparam int STATE_LSB      = PROTID_LSB + PROTID_WIDTH;

  typedef logic [LANE_WIDTH-1:0]   lane_t;
  typedef logic [WORD_WIDTH-1:0]   word_t;
  typedef logic [DELAY_WIDTH-1:0]  delay_t;
  typedef logic [DATA_WIDTH-1:0]   data_t;
  typedef logic [CRC_WIDTH-1:0]    crc_t;
  typedef logic [STATE_WIDTH-1:0]  lstate_t;
  typedef logic [PROTID_WIDTH-1:0] protid_t;
  typedef logic [MARKER_WIDTH-1:0] marker_t;

  // Transmit bring-up sequence
  typedef enum logic [1:0] {
    SYNC_OFFLINE,
    SYNC_STROBE,
    SYNC_ONLINE
  } sync_state_e;

endpackage

//--- hw/ll_auto_sync.sv
// Link bring-up sequencer with tx/rx online delays and strobe/marker generation
`timescale 1ns/10ps

module ll_auto_sync (
  input  logic               clk_wr,
  input  logic               rst_n,
  input  logic               tx_online,
  input  logic               rx_online,
  input  lpif_pkg::delay_t   delay_x_value,
  input  lpif_pkg::delay_t   delay_y_value,
  input  lpif_pkg::delay_t   delay_z_value,
  output logic               tx_online_delay,
  output logic               rx_online_delay,
  output logic               tx_auto_stb_userbit,
  output lpif_pkg::marker_t  tx_auto_mrk_userbit
);

  import lpif_pkg::*;

  // Edges seen with tx_online high
  delay_t      tx_cnt;
  delay_t      tx_cnt_nxt;
  // Edges seen with rx_online high
  delay_t      rx_cnt;
  sync_state_e sync_state;
  sync_state_e sync_state_nxt;
  // Low phase drives 01, high phase 10
  logic        mrk_phase;
  logic        tx_active;

  //////////////////////////////////////////////////////////////////////
  // Transmit sequencer
  //////////////////////////////////////////////////////////////////////

  // Saturating count, cleared while offline
  always_comb begin
    tx_cnt_nxt = tx_cnt;
    if (!tx_online) begin
      tx_cnt_nxt = '0;
    end else if (tx_cnt != '1) begin
      tx_cnt_nxt = tx_cnt + 1'b1;
    end
  end

  // State runs one edge ahead of the lane register in concat,
  // so lanes show the strobe from edge E+z and payload from E+y
  always_comb begin
    sync_state_nxt = sync_state;
    case (sync_state)
      SYNC_OFFLINE: begin
        if (tx_online && (tx_cnt_nxt >= delay_y_value)) begin
          sync_state_nxt = SYNC_ONLINE;
        end else if (tx_online && (tx_cnt_nxt >= delay_z_value)) begin
          sync_state_nxt = SYNC_STROBE;
        end
      end
      SYNC_STROBE: begin
        if (!tx_online) begin
          sync_state_nxt = SYNC_OFFLINE;
        end else if (tx_cnt_nxt >= delay_y_value) begin
          sync_state_nxt = SYNC_ONLINE;
        end
      end
      SYNC_ONLINE: begin
        if (!tx_online) begin
          sync_state_nxt = SYNC_OFFLINE;
        end
      end
      default: sync_state_nxt = SYNC_OFFLINE;
    endcase
  end

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      tx_cnt     <= '0;
      sync_state <= SYNC_OFFLINE;
      mrk_phase  <= 1'b0;
    end else begin
      tx_cnt     <= tx_cnt_nxt;
      sync_state <= sync_state_nxt;
      // First strobe cycle always starts on 01
      if (sync_state == SYNC_OFFLINE) begin
        mrk_phase <= 1'b0;
      end else begin
        mrk_phase <= ~mrk_phase;
      end
    end
  end

  // Dropping tx_online kills strobe, marker and data at once
  assign tx_active           = tx_online && (sync_state != SYNC_OFFLINE);
  assign tx_auto_stb_userbit = tx_active;
  assign tx_auto_mrk_userbit = !tx_active ? '0 : (mrk_phase ? 2'b10 : 2'b01);
  assign tx_online_delay     = tx_online && (sync_state == SYNC_ONLINE);

  //////////////////////////////////////////////////////////////////////
  // Receive online delay
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      rx_cnt          <= '0;
      rx_online_delay <= 1'b0;
    end else begin
      if (!rx_online) begin
        rx_cnt <= '0;
      end else if (rx_cnt != '1) begin
        rx_cnt <= rx_cnt + 1'b1;
      end
      // High from edge R+x, low on the edge that samples rx_online low
      rx_online_delay <= rx_online && (rx_cnt >= delay_x_value);
    end
  end

endmodule

//--- hw/lpif_txrx_x4_h1_master_name.sv
// User-side packing of downstream fields and registered unpacking of upstream fields
`timescale 1ns/10ps

module lpif_txrx_x4_h1_master_name (
  input  logic               clk_wr,
  input  logic               rst_n,

  // Downstream user fields
  input  lpif_pkg::lstate_t  dstrm_state,
  input  lpif_pkg::protid_t  dstrm_protid,
  input  lpif_pkg::data_t    dstrm_data,
  input  logic               dstrm_dvalid,
  input  lpif_pkg::crc_t     dstrm_crc,
  input  logic               dstrm_crc_valid,
  input  logic               dstrm_valid,

  // Packed words to and from the lane block
  output lpif_pkg::word_t    txfifo_downstream_data,
  input  lpif_pkg::word_t    rxfifo_upstream_data,
  input  logic               rx_word_ok,
  input  logic               rx_online_delay,

  // Upstream user fields
  output lpif_pkg::lstate_t  ustrm_state,
  output lpif_pkg::protid_t  ustrm_protid,
  output lpif_pkg::data_t    ustrm_data,
  output logic               ustrm_dvalid,
  output lpif_pkg::crc_t     ustrm_crc,
  output logic               ustrm_crc_valid,
  output logic               ustrm_valid
);

  import lpif_pkg::*;

  // Word is usable only with all strobes present and rx online
  logic rx_qualified;

  //////////////////////////////////////////////////////////////////////
  // Downstream packing
  //////////////////////////////////////////////////////////////////////

  // Valid in bit 0, state in the top four bits
  assign txfifo_downstream_data = {dstrm_state,
                                   dstrm_protid,
                                   dstrm_data,
                                   dstrm_dvalid,
                                   dstrm_crc,
                                   dstrm_crc_valid,
                                   dstrm_valid};

  //////////////////////////////////////////////////////////////////////
  // Upstream unpacking
  //////////////////////////////////////////////////////////////////////

  assign rx_qualified = rx_word_ok && rx_online_delay;

  // Payload fields pass through untouched
  always_ff @(posedge clk_wr) begin
    ustrm_state  <= rxfifo_upstream_data[STATE_LSB +: STATE_WIDTH];
    ustrm_protid <= rxfifo_upstream_data[PROTID_LSB +: PROTID_WIDTH];
    ustrm_data   <= rxfifo_upstream_data[DATA_LSB +: DATA_WIDTH];
    ustrm_crc    <= rxfifo_upstream_data[CRC_LSB +: CRC_WIDTH];
  end

  // Valids dropped on a missing strobe or before rx online
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      ustrm_valid     <= 1'b0;
      ustrm_dvalid    <= 1'b0;
      ustrm_crc_valid <= 1'b0;
    end else begin
      ustrm_valid     <= rx_qualified && rxfifo_upstream_data[VALID_BIT];
      ustrm_dvalid    <= rx_qualified && rxfifo_upstream_data[DVALID_BIT];
      ustrm_crc_valid <= rx_qualified && rxfifo_upstream_data[CRC_VALID_BIT];
    end
  end

endmodule

//--- hw/lpif_txrx_x4_h1_master_concat.sv
// PHY-side lane striping with strobe and marker insertion, and lane reassembly
`timescale 1ns/10ps

module lpif_txrx_x4_h1_master_concat (
  input  logic               clk_wr,
  input  logic               rst_n,
  input  logic               tx_online,

  // Word and sync bits from the user side
  input  lpif_pkg::word_t    tx_downstream_data,
  input  logic               tx_stb_userbit,
  input  lpif_pkg::marker_t  tx_mrk_userbit,

  // Transmit lanes
  output lpif_pkg::lane_t    tx_phy0,
  output lpif_pkg::lane_t    tx_phy1,
  output lpif_pkg::lane_t    tx_phy2,
  output lpif_pkg::lane_t    tx_phy3,

  // Receive lanes
  input  lpif_pkg::lane_t    rx_phy0,
  input  lpif_pkg::lane_t    rx_phy1,
  input  lpif_pkg::lane_t    rx_phy2,
  input  lpif_pkg::lane_t    rx_phy3,

  output lpif_pkg::word_t    rx_upstream_data,
  output logic               rx_word_ok
);

  import lpif_pkg::*;

  // Word padded to four full lane payloads
  logic [PAYLOAD_BITS-1:0] tx_payload;
  lane_t                   tx_lane_d [LANE_COUNT];
  lane_t                   tx_lane_q [LANE_COUNT];
  lane_t                   rx_lane   [LANE_COUNT];

  //////////////////////////////////////////////////////////////////////
  // Transmit striping
  //////////////////////////////////////////////////////////////////////

  // Payload zero until the link is fully up
  always_comb begin
    tx_payload = '0;
    if (tx_online) begin
      tx_payload[WORD_WIDTH-1:0] = tx_downstream_data;
    end
  end

  // Lane k carries word bits 78k and up
  // Marker bit 0 on even lanes, bit 1 on odd lanes
  always_comb begin
    for (int k = 0; k < LANE_COUNT; k++) begin
      tx_lane_d[k] = {tx_mrk_userbit[k % MARKER_WIDTH],
                      tx_payload[k*LANE_DATA_BITS +: LANE_DATA_BITS],
                      tx_stb_userbit};
    end
  end

  // One cycle from word in to lanes out
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      tx_lane_q <= '{default: '0};
    end else begin
      tx_lane_q <= tx_lane_d;
    end
  end

  assign tx_phy0 = tx_lane_q[0];
  assign tx_phy1 = tx_lane_q[1];
  assign tx_phy2 = tx_lane_q[2];
  assign tx_phy3 = tx_lane_q[3];

  //////////////////////////////////////////////////////////////////////
  // Receive reassembly
  //////////////////////////////////////////////////////////////////////

  assign rx_lane[0] = rx_phy0;
  assign rx_lane[1] = rx_phy1;
  assign rx_lane[2] = rx_phy2;
  assign rx_lane[3] = rx_phy3;

  // Strip strobe and marker, lower lanes carry full payloads
  always_comb begin
    rx_upstream_data = '0;
    for (int k = 0; k < LANE_COUNT - 1; k++) begin
      rx_upstream_data[k*LANE_DATA_BITS +: LANE_DATA_BITS] = rx_lane[k][LANE_DATA_BITS:1];
    end
    // Top lane only partly filled, padding ignored
    rx_upstream_data[WORD_WIDTH-1 -: LAST_LANE_BITS] =
      rx_lane[LANE_COUNT-1][LAST_LANE_BITS:1];
  end

  // All four strobes must be present
  always_comb begin
    rx_word_ok = 1'b1;
    for (int k = 0; k < LANE_COUNT; k++) begin
      rx_word_ok = rx_word_ok & rx_lane[k][0];
    end
  end

endmodule

//--- hw/lpif_txrx_x4_h1_master_top.sv
// Top level wiring auto-sync, user-side name block and PHY-side concat block
`timescale 1ns/10ps

module lpif_txrx_x4_h1_master_top (
  input  logic               clk_wr,
  input  logic               rst_n,

  // Link control
  input  logic               tx_online,
  input  logic               rx_online,
  input  lpif_pkg::delay_t   delay_x_value,
  input  lpif_pkg::delay_t   delay_y_value,
  input  lpif_pkg::delay_t   delay_z_value,

  // PHY lanes
  output lpif_pkg::lane_t    tx_phy0,
  input  lpif_pkg::lane_t    rx_phy0,
  output lpif_pkg::lane_t    tx_phy1,
  input  lpif_pkg::lane_t    rx_phy1,
  output lpif_pkg::lane_t    tx_phy2,
  input  lpif_pkg::lane_t    rx_phy2,
  output lpif_pkg::lane_t    tx_phy3,
  input  lpif_pkg::lane_t    rx_phy3,

  // Downstream channel
  input  lpif_pkg::lstate_t  dstrm_state,
  input  lpif_pkg::protid_t  dstrm_protid,
  input  lpif_pkg::data_t    dstrm_data,
  input  logic               dstrm_dvalid,
  input  lpif_pkg::crc_t     dstrm_crc,
  input  logic               dstrm_crc_valid,
  input  logic               dstrm_valid,

  // Upstream channel
  output lpif_pkg::lstate_t  ustrm_state,
  output lpif_pkg::protid_t  ustrm_protid,
  output lpif_pkg::data_t    ustrm_data,
  output logic               ustrm_dvalid,
  output lpif_pkg::crc_t     ustrm_crc,
  output logic               ustrm_crc_valid,
  output logic               ustrm_valid
);

  import lpif_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Interconnect
  //////////////////////////////////////////////////////////////////////

  // Words go straight between packer and lane block
  word_t   tx_downstream_data;
  word_t   rx_upstream_data;
  logic    rx_word_ok;
  logic    tx_online_delay;
  logic    rx_online_delay;
  logic    tx_auto_stb_userbit;
  marker_t tx_auto_mrk_userbit;

  ll_auto_sync ll_auto_sync_i (
    .clk_wr              (clk_wr),
    .rst_n               (rst_n),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .delay_x_value       (delay_x_value),
    .delay_y_value       (delay_y_value),
    .delay_z_value       (delay_z_value),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_stb_userbit (tx_auto_stb_userbit),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit)
  );

  // User side
  lpif_txrx_x4_h1_master_name lpif_txrx_x4_h1_master_name (
    .clk_wr                 (clk_wr),
    .rst_n                  (rst_n),
    .dstrm_state            (dstrm_state),
    .dstrm_protid           (dstrm_protid),
    .dstrm_data             (dstrm_data),
    .dstrm_dvalid           (dstrm_dvalid),
    .dstrm_crc              (dstrm_crc),
    .dstrm_crc_valid        (dstrm_crc_valid),
    .dstrm_valid            (dstrm_valid),
    .txfifo_downstream_data (tx_downstream_data),
    .rxfifo_upstream_data   (rx_upstream_data),
    .rx_word_ok             (rx_word_ok),
    .rx_online_delay        (rx_online_delay),
    .ustrm_state            (ustrm_state),
    .ustrm_protid           (ustrm_protid),
    .ustrm_data             (ustrm_data),
    .ustrm_dvalid           (ustrm_dvalid),
    .ustrm_crc              (ustrm_crc),
    .ustrm_crc_valid        (ustrm_crc_valid),
    .ustrm_valid            (ustrm_valid)
  );

  // PHY side, payload gated by the delayed tx online
  lpif_txrx_x4_h1_master_concat lpif_txrx_x4_h1_master_concat (
    .clk_wr             (clk_wr),
    .rst_n              (rst_n),
    .tx_online          (tx_online_delay),
    .tx_downstream_data (tx_downstream_data),
    .tx_stb_userbit     (tx_auto_stb_userbit),
    .tx_mrk_userbit     (tx_auto_mrk_userbit),
    .tx_phy0            (tx_phy0),
    .tx_phy1            (tx_phy1),
    .tx_phy2            (tx_phy2),
    .tx_phy3            (tx_phy3),
    .rx_phy0            (rx_phy0),
    .rx_phy1            (rx_phy1),
    .rx_phy2            (rx_phy2),
    .rx_phy3            (rx_phy3),
    .rx_upstream_data   (rx_upstream_data),
    .rx_word_ok         (rx_word_ok)
  );

endmodule

//--- tb/lpif_txrx_tb.sv
// Directed testbench for the x4 logic-link top with lane loopback and strobe fault injection
`timescale 1ns/10ps

module lpif_txrx_tb;

  import lpif_pkg::*;

  localparam int          RESET_CYCLES = 5;
  // Scripted run is a few hundred cycles, limit leaves wide margin
  localparam int          MAX_CYCLES   = 2000;
  localparam int          DLY_X        = 5;
  localparam int          DLY_Y        = 8;
  localparam int          DLY_Z        = 3;
  localparam int unsigned SEED         = 32'h7cdab6a2;

  logic        clk_wr = 1'b0;
  logic        rst_n;
  logic        tx_online;
  logic        rx_online;
  delay_t      delay_x_value;
  delay_t      delay_y_value;
  delay_t      delay_z_value;
  lane_t       tx_phy0, tx_phy1, tx_phy2, tx_phy3;
  lane_t       rx_phy0, rx_phy1, rx_phy2, rx_phy3;
  lstate_t     dstrm_state, ustrm_state;
  protid_t     dstrm_protid, ustrm_protid;
  data_t       dstrm_data, ustrm_data;
  logic        dstrm_dvalid, ustrm_dvalid;
  crc_t        dstrm_crc, ustrm_crc;
  logic        dstrm_crc_valid, ustrm_crc_valid;
  logic        dstrm_valid, ustrm_valid;
  // One bit per lane, clears that lane's strobe on the way back
  logic [3:0]  strobe_kill;
  // Words driven at the last three edges, newest first
  word_t       w_cur, w_d1, w_d2;
  int          cycle_count = 0;

  always #20 clk_wr = ~clk_wr;

  // Loopback with strobe corruption
  assign rx_phy0 = tx_phy0 & ~{{79{1'b0}}, strobe_kill[0]};
  assign rx_phy1 = tx_phy1 & ~{{79{1'b0}}, strobe_kill[1]};
  assign rx_phy2 = tx_phy2 & ~{{79{1'b0}}, strobe_kill[2]};
  assign rx_phy3 = tx_phy3 & ~{{79{1'b0}}, strobe_kill[3]};

  lpif_txrx_x4_h1_master_top UUT (
    .clk_wr (clk_wr), .rst_n (rst_n),
    .tx_online (tx_online), .rx_online (rx_online),
    .delay_x_value (delay_x_value), .delay_y_value (delay_y_value),
    .delay_z_value (delay_z_value),
    .tx_phy0 (tx_phy0), .rx_phy0 (rx_phy0), .tx_phy1 (tx_phy1), .rx_phy1 (rx_phy1),
    .tx_phy2 (tx_phy2), .rx_phy2 (rx_phy2), .tx_phy3 (tx_phy3), .rx_phy3 (rx_phy3),
    .dstrm_state (dstrm_state), .dstrm_protid (dstrm_protid), .dstrm_data (dstrm_data),
    .dstrm_dvalid (dstrm_dvalid), .dstrm_crc (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid), .dstrm_valid (dstrm_valid),
    .ustrm_state (ustrm_state), .ustrm_protid (ustrm_protid), .ustrm_data (ustrm_data),
    .ustrm_dvalid (ustrm_dvalid), .ustrm_crc (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid), .ustrm_valid (ustrm_valid)
  );

  always @(posedge clk_wr) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: no verdict after %0d clock cycles", MAX_CYCLES);
      $display("Simulation FAILED");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus and reference helpers
  //////////////////////////////////////////////////////////////////////

  function automatic word_t random_word(input logic all_valid);
    logic [287:0] raw;
    word_t        w;
    raw = '0;
    for (int i = 0; i < 9; i++) begin
      raw = {raw[255:0], $urandom};
    end
    w = raw[280:0];
    // Valid, crc_valid and dvalid set
    if (all_valid) begin
      w[0]  = 1'b1;
      w[1]  = 1'b1;
      w[18] = 1'b1;
    end
    return w;
  endfunction

  // Lane k holds word bits 78k up, strobe below, marker above
  function automatic lane_t expected_lane(input word_t w, input int k, input logic stb,
                                          input marker_t mrk, input logic pay);
    logic [311:0] padded;
    logic [77:0]  payload;
    logic         mrk_bit;
    padded = '0;
    if (pay) begin
      padded[280:0] = w;
    end
    payload = 78'(padded >> (k * 78));
    mrk_bit = (k % 2 == 0) ? mrk[0] : mrk[1];
    return {mrk_bit, payload, stb};
  endfunction

  // One clock: drive at the rising edge, return at the falling edge
  task automatic step(input word_t w, input logic tx_on, input logic rx_on,
                      input logic [3:0] kill);
    @(posedge clk_wr);
    dstrm_state     <= w[280:277];
    dstrm_protid    <= w[276:275];
    dstrm_data      <= w[274:19];
    dstrm_dvalid    <= w[18];
    dstrm_crc       <= w[17:2];
    dstrm_crc_valid <= w[1];
    dstrm_valid     <= w[0];
    tx_online       <= tx_on;
    rx_online       <= rx_on;
    strobe_kill     <= kill;
    w_d2  = w_d1;
    w_d1  = w_cur;
    w_cur = w;
    @(negedge clk_wr);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string msg);
    $display("Mismatch at %0t ns: %s", $time, msg);
    $display("Simulation FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s got %b expected %b", what, got, exp));
    end
  endtask

  task automatic check_lane(input lane_t got, input lane_t exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
    end
  endtask

  // Valid bits of the expected word cleared when not qualified
  task automatic check_word(input lstate_t st, input protid_t pid, input data_t data,
                            input logic dvalid, input crc_t crc, input logic crc_valid,
                            input logic valid, input word_t exp, input logic qual,
                            input string what);
    word_t got;
    word_t want;
    got      = {st, pid, data, dvalid, crc, crc_valid, valid};
    want     = exp;
    want[0]  = exp[0] & qual;
    want[1]  = exp[1] & qual;
    want[18] = exp[18] & qual;
    if (got !== want) begin
      report_mismatch($sformatf("%s ustrm word got %h expected %h", what, got, want));
    end
  endtask

  task automatic check_upstream(input word_t exp, input logic qual, input string what);
    check_word(ustrm_state, ustrm_protid, ustrm_data, ustrm_dvalid, ustrm_crc,
               ustrm_crc_valid, ustrm_valid, exp, qual, what);
  endtask

  task automatic check_valids_low(input string what);
    check_bit(ustrm_valid, 1'b0, {what, " ustrm_valid"});
    check_bit(ustrm_dvalid, 1'b0, {what, " ustrm_dvalid"});
    check_bit(ustrm_crc_valid, 1'b0, {what, " ustrm_crc_valid"});
  endtask

  // Lanes carry the word sampled one edge back
  task automatic check_all_lanes(input logic stb, input marker_t mrk, input logic pay,
                                 input string what);
    check_lane(tx_phy0, expected_lane(w_d1, 0, stb, mrk, pay), {what, " tx_phy0"});
    check_lane(tx_phy1, expected_lane(w_d1, 1, stb, mrk, pay), {what, " tx_phy1"});
    check_lane(tx_phy2, expected_lane(w_d1, 2, stb, mrk, pay), {what, " tx_phy2"});
    check_lane(tx_phy3, expected_lane(w_d1, 3, stb, mrk, pay), {what, " tx_phy3"});
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic check_reset_state();
    for (int i = 0; i < 3; i++) begin
      step('0, 1'b0, 1'b0, 4'b0000);
      check_all_lanes(1'b0, 2'b00, 1'b0, "after reset");
      check_valids_low("after reset");
    end
  endtask

  // Step i is edge E+i-1, E samples tx_online high
  task automatic check_bring_up(input logic rx_on);
    int          j;
    logic        stb;
    logic        pay;
    marker_t     mrk;
    sync_state_e phase;
    for (int i = 0; i < 15; i++) begin
      step(random_word(1'b0), 1'b1, rx_on, 4'b0000);
      j   = i - 1;
      stb = (j >= DLY_Z);
      pay = (j >= DLY_Y);
      mrk = 2'b00;
      if (stb) begin
        mrk = ((j - DLY_Z) % 2 == 0) ? 2'b01 : 2'b10;
      end
      phase = pay ? SYNC_ONLINE : (stb ? SYNC_STROBE : SYNC_OFFLINE);
      check_all_lanes(stb, mrk, pay, $sformatf("bring-up E+%0d %s", j, phase.name()));
    end
  endtask

  task automatic check_loopback();
    for (int i = 0; i < 10; i++) begin
      step(random_word(1'b0), 1'b1, 1'b1, 4'b0000);
    end
    for (int i = 0; i < 200; i++) begin
      step(random_word(1'b0), 1'b1, 1'b1, 4'b0000);
      check_upstream(w_d2, 1'b1, $sformatf("loopback word %0d", i));
    end
  endtask

  // Low from step 2, back once rx has been up DLY_X edges plus the register
  task automatic check_rx_gating();
    logic qual;
    for (int k = 0; k < 17; k++) begin
      step(random_word(1'b1), 1'b1, (k >= 4), 4'b0000);
      qual = (k <= 1) || (k >= 4 + 1 + DLY_X + 1);
      check_upstream(w_d2, qual, $sformatf("rx gating step %0d", k));
    end
  endtask

  // Strobe killed after step 3, valids low after step 4 only
  task automatic check_strobe_fault();
    for (int lane = 0; lane < 4; lane++) begin
      for (int k = 0; k < 9; k++) begin
        step(random_word(1'b1), 1'b1, 1'b1, (k == 3) ? (4'b0001 << lane) : 4'b0000);
        check_upstream(w_d2, (k != 4), $sformatf("strobe fault lane %0d step %0d", lane, k));
      end
    end
  endtask

  task automatic check_tx_drop();
    for (int k = 0; k < 4; k++) begin
      step(random_word(1'b1), 1'b0, 1'b1, 4'b0000);
      if (k >= 1) begin
        check_all_lanes(1'b0, 2'b00, 1'b0, $sformatf("tx drop step %0d", k));
      end
      if (k >= 2) begin
        check_valids_low($sformatf("tx drop step %0d", k));
      end
    end
    // Same delays, sequence starts over
    check_bring_up(1'b1);
  endtask

  initial begin
    void'($urandom(SEED));
    w_cur = '0;
    w_d1  = '0;
    w_d2  = '0;
    rst_n           <= 1'b0;
    tx_online       <= 1'b0;
    rx_online       <= 1'b0;
    delay_x_value   <= 16'(DLY_X);
    delay_y_value   <= 16'(DLY_Y);
    delay_z_value   <= 16'(DLY_Z);
    strobe_kill     <= 4'b0000;
    dstrm_state     <= '0;
    dstrm_protid    <= '0;
    dstrm_data      <= '0;
    dstrm_dvalid    <= 1'b0;
    dstrm_crc       <= '0;
    dstrm_crc_valid <= 1'b0;
    dstrm_valid     <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_wr);
    rst_n <= 1'b1;
    @(negedge clk_wr);
    check_reset_state();
    check_bring_up(1'b0);
    check_loopback();
    check_rx_gating();
    check_strobe_fault();
    check_tx_drop();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- project.f
hw/lpif_pkg.sv
hw/ll_auto_sync.sv
hw/lpif_txrx_x4_h1_master_name.sv
hw/lpif_txrx_x4_h1_master_concat.sv
hw/lpif_txrx_x4_h1_master_top.sv
tb/lpif_txrx_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the link testbench with Verilator, runs it and reads the verdict from the log

cd "$(dirname "$0")" || exit 1

TOP=lpif_txrx_tb
OBJ_DIR=obj_dir
LOG=sim.log

echo "Building $TOP"
verilator --binary --timing \
  --top-module "$TOP" \
  -Mdir "$OBJ_DIR" \
  -f project.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

if [ ! -x "./$OBJ_DIR/V$TOP" ]; then
  echo "Simulation executable not found"
  exit 1
fi

echo "Running $TOP"
"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulator exited with status $run_status"
fi

# Verdict comes from the log only
if grep -qx "Simulation PASSED" "$LOG"; then
  echo "Result: pass"
  exit 0
else
  echo "Result: fail"
  exit 1
fi
